/* source/ru_cfg_pkg.sv */
`default_nettype none

package ru_cfg_pkg;

    // ****************************************
    // fifo status
    // ****************************************

    // four status bits, msb first
    typedef struct packed {
        logic wfull;        // no room for another byte
        logic almost_full;  // wr_level at or above threshold
        logic rempty;       // no whole word buffered
        logic almost_empty; // rd_level at or below threshold
    } fifo_flags_t;

    // pointer wrap bit on top of the address bits
    localparam int PTR_WRAP_W = 1;

    // status as it comes out of reset
    localparam fifo_flags_t FLAGS_RST = '{
        wfull:        1'b0,
        almost_full:  1'b0,
        rempty:       1'b1,
        almost_empty: 1'b1
    };

endpackage : ru_cfg_pkg

`default_nettype wire

/* source/ru_data_pkg.sv */
`default_nettype none

package ru_data_pkg;

    // ****************************************
    // payload types
    // ****************************************

    typedef logic [7:0]  flash_byte_t;  // one byte shifted in from flash
    typedef logic [31:0] ru_word_t;     // byte 0 of a group in bits 7..0
    typedef logic [31:0] ru_csum_t;     // sum of delivered words, wraps

    // byte lanes per word
    localparam int BYTES_PER_WORD = 4;

    // bits of a byte address that pick the lane
    localparam int LANE_SEL_W = 2;

endpackage : ru_data_pkg

`default_nettype wire

/* source/ru_byte_deser.sv */
`timescale 1ns/1ps
`default_nettype none

module ru_byte_deser
    import ru_data_pkg::*;
(
    input  logic        rclk,
    input  logic        rrst,
    input  logic        bit_in,       // serial flash data, msb first
    input  logic        bit_strobe,   // one bit taken per high cycle
    input  logic        frame_start,  // drop any partial byte
    output logic        byte_vld,
    output flash_byte_t byte_out
);

    logic [6:0] shift_q;  // first seven bits of the byte in flight
    logic [2:0] bit_cnt;  // bits already held in shift_q

    // ****************************************
    // bit counter and valid pulse
    // ****************************************
    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
        begin
            bit_cnt  <= 3'd0;
            byte_vld <= 1'b0;
        end
        else
        begin
            byte_vld <= 1'b0;
            if (frame_start)
                bit_cnt <= bit_strobe ? 3'd1 : 3'd0;  // same-cycle bit opens the new byte
            else if (bit_strobe)
            begin
                bit_cnt <= bit_cnt + 3'd1;            // wraps to 0 after bit 8
                if (bit_cnt == 3'd7)
                    byte_vld <= 1'b1;
            end
        end
    end

    // data path, no reset
    always_ff @(posedge rclk)
    begin
        if (bit_strobe)
        begin
            shift_q <= {shift_q[5:0], bit_in};
            if (!frame_start && bit_cnt == 3'd7)
                byte_out <= {shift_q, bit_in};  // eighth bit lands in bit 0
        end
    end

endmodule : ru_byte_deser

`default_nettype wire

/* source/ru_fifo_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module ru_fifo_ctrl
    import ru_cfg_pkg::*;
#(
    parameter int WR_DEPTH_WIDTH   = 9,    // byte address bits
    parameter int RD_DEPTH_WIDTH   = 7,    // word address bits
    parameter int ALMOST_FULL_NUM  = 500,  // bytes
    parameter int ALMOST_EMPTY_NUM = 2     // words
) (
    input  logic                      rclk,
    input  logic                      rrst,
    input  logic                      w_en,
    input  logic                      r_en,
    output logic [WR_DEPTH_WIDTH-1:0] waddr,
    output logic [RD_DEPTH_WIDTH-1:0] raddr,
    output logic                      w_fire,
    output logic                      r_fire,
    output fifo_flags_t               flags,
    output logic [WR_DEPTH_WIDTH:0]   wr_level,
    output logic [RD_DEPTH_WIDTH:0]   rd_level
);

    localparam int WP_W = WR_DEPTH_WIDTH + PTR_WRAP_W;  // write pointer incl wrap
    localparam int RP_W = RD_DEPTH_WIDTH + PTR_WRAP_W;  // read pointer incl wrap

    logic [WP_W-1:0] wptr;     // current write pointer, bytes
    logic [WP_W-1:0] wnext;    // write pointer after this cycle
    logic [WP_W-1:0] rnext_w;  // read pointer seen in byte units
    logic [RP_W-1:0] rptr;     // current read pointer, words
    logic [RP_W-1:0] rnext;
    logic [RP_W-1:0] wnext_r;  // write pointer seen in word units
    logic            wfull_q;
    logic            rempty_q;

    // ****************************************
    // enables and next pointers
    // ****************************************
    assign w_fire = w_en & ~wfull_q;   // full fifo drops the byte
    assign r_fire = r_en & ~rempty_q;  // empty fifo refuses

    assign wnext = wptr + WP_W'(w_fire);
    assign rnext = rptr + RP_W'(r_fire);

    assign waddr = wptr[WR_DEPTH_WIDTH-1:0];  // wrap bit stripped
    assign raddr = rptr[RD_DEPTH_WIDTH-1:0];

    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
        begin
            wptr <= '0;
            rptr <= '0;
        end
        else
        begin
            wptr <= wnext;
            rptr <= rnext;
        end
    end

    // line up pointers of different widths
    generate
        if (WR_DEPTH_WIDTH > RD_DEPTH_WIDTH)
        begin : g_wr_wide
            // pad read side with zero lanes, drop write lanes
            assign rnext_w = {rnext, {(WR_DEPTH_WIDTH-RD_DEPTH_WIDTH){1'b0}}};
            assign wnext_r = wnext[WP_W-1 -: RP_W];  // partial word reads as empty
        end
        else if (WR_DEPTH_WIDTH < RD_DEPTH_WIDTH)
        begin : g_rd_wide
            assign rnext_w = rnext[RP_W-1 -: WP_W];
            assign wnext_r = {wnext, {(RD_DEPTH_WIDTH-WR_DEPTH_WIDTH){1'b0}}};
        end
        else
        begin : g_same
            assign rnext_w = rnext;
            assign wnext_r = wnext;
        end
    endgenerate

    // ****************************************
    // registered full, empty, levels
    // ****************************************
    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
        begin
            wfull_q  <= FLAGS_RST.wfull;
            rempty_q <= FLAGS_RST.rempty;
            wr_level <= '0;
            rd_level <= '0;
        end
        else
        begin
            // wrap bits differ, address bits equal
            wfull_q  <= (wnext[WP_W-1] != rnext_w[WP_W-1])
                     && (wnext[WP_W-2:0] == rnext_w[WP_W-2:0]);
            rempty_q <= (wnext_r == rnext);
            wr_level <= wnext - rnext_w;  // modulo difference covers the wrap
            rd_level <= wnext_r - rnext;
        end
    end

    // almost flags straight off the levels
    assign flags.wfull        = wfull_q;
    assign flags.almost_full  = (wr_level >= ALMOST_FULL_NUM);
    assign flags.rempty       = rempty_q;
    assign flags.almost_empty = (rd_level <= ALMOST_EMPTY_NUM);

endmodule : ru_fifo_ctrl

`default_nettype wire

/* source/ru_fifo_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module ru_fifo_ram
    import ru_data_pkg::*;
#(
    parameter int WR_DEPTH_WIDTH = 9
) (
    input  logic                                 rclk,
    input  logic                                 w_fire,
    input  logic [WR_DEPTH_WIDTH-1:0]            waddr,
    input  flash_byte_t                          wdata,
    input  logic                                 r_fire,
    input  logic [WR_DEPTH_WIDTH-LANE_SEL_W-1:0] raddr,
    output ru_word_t                             rdata
);

    localparam int ROW_W  = WR_DEPTH_WIDTH - LANE_SEL_W;  // row index bits
    localparam int ROWS   = 1 << ROW_W;
    localparam int BYTE_W = $bits(flash_byte_t);

    logic [ROW_W-1:0]      wrow;   // upper byte address bits
    logic [LANE_SEL_W-1:0] wlane;  // low two bits

    assign wrow  = waddr[WR_DEPTH_WIDTH-1:LANE_SEL_W];
    assign wlane = waddr[LANE_SEL_W-1:0];

    // ****************************************
    // one byte-wide array per lane
    // ****************************************
    genvar l;
    generate
        for (l = 0; l < BYTES_PER_WORD; l++)
        begin : g_lane
            flash_byte_t mem [ROWS];

            always_ff @(posedge rclk)
            begin
                if (w_fire && wlane == LANE_SEL_W'(l))
                    mem[wrow] <= wdata;                         // byte lane write
                if (r_fire)
                    rdata[l*BYTE_W +: BYTE_W] <= mem[raddr];   // lane l of the row
            end
        end
    endgenerate

endmodule : ru_fifo_ram

`default_nettype wire

/* source/ru_word_reader.sv */
`timescale 1ns/1ps
`default_nettype none

module ru_word_reader
    import ru_data_pkg::*;
(
    input  logic     rclk,
    input  logic     rrst,
    input  logic     rd_req,     // host request
    input  logic     r_fire,     // request taken by the controller
    input  ru_word_t ram_rdata,  // valid the cycle after r_fire
    input  logic     csum_clr,
    output logic     word_vld,
    output ru_word_t word_out,
    output logic     rd_miss,
    output ru_csum_t csum
);

    logic     fire_q;    // r_fire lined up with ram data
    ru_csum_t csum_base;

    assign csum_base = csum_clr ? '0 : csum;  // clear wins, same-cycle word still counts

    // ****************************************
    // control and checksum
    // ****************************************
    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
        begin
            fire_q   <= 1'b0;
            word_vld <= 1'b0;
            rd_miss  <= 1'b0;
            csum     <= '0;
        end
        else
        begin
            fire_q   <= r_fire;
            word_vld <= fire_q;
            rd_miss  <= rd_req & ~r_fire;  // refused, fifo empty
            csum     <= csum_base + (fire_q ? ram_rdata : '0);
        end
    end

    // output word, payload only
    always_ff @(posedge rclk)
    begin
        if (fire_q)
            word_out <= ram_rdata;
    end

endmodule : ru_word_reader

`default_nettype wire

/* source/ru_rd_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ru_rd_top
    import ru_cfg_pkg::*;
    import ru_data_pkg::*;
#(
    parameter int WR_DEPTH_WIDTH   = 9,    // 512 bytes
    parameter int ALMOST_FULL_NUM  = 500,  // bytes
    parameter int ALMOST_EMPTY_NUM = 2,    // words
    localparam int RD_DEPTH_WIDTH  = WR_DEPTH_WIDTH - LANE_SEL_W
) (
    input  logic                    rclk,
    input  logic                    rrst,
    input  logic                    bit_in,
    input  logic                    bit_strobe,
    input  logic                    frame_start,
    input  logic                    rd_req,
    input  logic                    csum_clr,
    output logic                    word_vld,
    output ru_word_t                word_out,
    output logic                    rd_miss,
    output ru_csum_t                csum,
    output fifo_flags_t             flags,
    output logic [WR_DEPTH_WIDTH:0] wr_level,  // bytes
    output logic [RD_DEPTH_WIDTH:0] rd_level   // words
);

    logic                      byte_vld;
    flash_byte_t               byte_out;
    logic                      w_fire;
    logic                      r_fire;
    logic [WR_DEPTH_WIDTH-1:0] waddr;
    logic [RD_DEPTH_WIDTH-1:0] raddr;
    ru_word_t                  ram_rdata;

    // ****************************************
    // stage 1, bits to bytes
    // ****************************************
    ru_byte_deser u_byte_deser (
        .rclk        (rclk),
        .rrst        (rrst),
        .bit_in      (bit_in),
        .bit_strobe  (bit_strobe),
        .frame_start (frame_start),
        .byte_vld    (byte_vld),
        .byte_out    (byte_out)
    );

    // stage 2, fifo control and storage
    ru_fifo_ctrl #(
        .WR_DEPTH_WIDTH   (WR_DEPTH_WIDTH),
        .RD_DEPTH_WIDTH   (RD_DEPTH_WIDTH),
        .ALMOST_FULL_NUM  (ALMOST_FULL_NUM),
        .ALMOST_EMPTY_NUM (ALMOST_EMPTY_NUM)
    ) u_fifo_ctrl (
        .rclk     (rclk),
        .rrst     (rrst),
        .w_en     (byte_vld),
        .r_en     (rd_req),
        .waddr    (waddr),
        .raddr    (raddr),
        .w_fire   (w_fire),
        .r_fire   (r_fire),
        .flags    (flags),
        .wr_level (wr_level),
        .rd_level (rd_level)
    );

    ru_fifo_ram #(
        .WR_DEPTH_WIDTH (WR_DEPTH_WIDTH)
    ) u_fifo_ram (
        .rclk   (rclk),
        .w_fire (w_fire),
        .waddr  (waddr),
        .wdata  (byte_out),
        .r_fire (r_fire),
        .raddr  (raddr),
        .rdata  (ram_rdata)
    );

    // ****************************************
    // stage 3, word out and checksum
    // ****************************************
    ru_word_reader u_word_reader (
        .rclk      (rclk),
        .rrst      (rrst),
        .rd_req    (rd_req),
        .r_fire    (r_fire),
        .ram_rdata (ram_rdata),
        .csum_clr  (csum_clr),
        .word_vld  (word_vld),
        .word_out  (word_out),
        .rd_miss   (rd_miss),
        .csum      (csum)
    );

endmodule : ru_rd_top

`default_nettype wire

/* dv/tb_ru_rd_tests.svh */
`ifndef TB_RU_RD_TESTS_SVH
`define TB_RU_RD_TESTS_SVH

// ****************************************
// stimulus helpers
// ****************************************
task automatic apply_reset();
    @(posedge rclk);
    rrst <= 1'b1;
    repeat (4) @(posedge rclk);  // four cycles held
    rrst <= 1'b0;
    byte_q.delete();
    csum_model = '0;
endtask

// random bytes msb first after an optional partial byte cut by frame_start
task automatic send_bytes(input int n, input int cut_bits);
    flash_byte_t b;
    int          i;
    int          k;
    for (i = 0; i < cut_bits; i++)
    begin
        @(posedge rclk);
        bit_in     <= 1'b1;
        bit_strobe <= 1'b1;
    end
    @(posedge rclk);
    bit_strobe  <= 1'b0;
    frame_start <= (cut_bits > 0);  // drops the stray bits
    for (i = 0; i < n; i++)
    begin
        b = flash_byte_t'($random(seed));
        if (byte_q.size() < DEPTH)
            byte_q.push_back(b);    // full fifo drops the rest
        for (k = 7; k >= 0; k--)
        begin
            @(posedge rclk);
            frame_start <= 1'b0;
            bit_in      <= b[k];
            bit_strobe  <= 1'b1;
        end
    end
    @(posedge rclk);
    frame_start <= 1'b0;
    bit_strobe  <= 1'b0;
endtask

// k reads back to back and each word checked against the model
task automatic read_words(input int k);
    ru_word_t exp;
    int       issued;
    int       got;
    int       n;
    issued = 0;
    got    = 0;
    n      = 0;
    while (got < k && n < WAIT_MAX)
    begin
        @(posedge rclk);
        rd_req <= (issued < k);  // one request per cycle
        if (issued < k)
            issued++;
        @(negedge rclk);
        if (word_vld)
        begin
            exp = {byte_q[3], byte_q[2], byte_q[1], byte_q[0]};  // byte 0 in low lane
            repeat (BYTES_PER_WORD) void'(byte_q.pop_front());
            csum_model += exp;                                    // wraps mod 2^32
            check_word("word_out", word_out, exp);
            got++;
        end
        n++;
    end
    if (got < k)
        report_error("timeout waiting for word_vld");
endtask

task automatic clear_csum();
    @(posedge rclk);
    csum_clr <= 1'b1;
    @(posedge rclk);
    csum_clr <= 1'b0;
    csum_model = '0;
    @(negedge rclk);
    check_csum(csum, csum_model);
endtask

// ****************************************
// directed tests
// ****************************************
task automatic test_reset_state();
    apply_reset();
    check_fifo_state();             // empty and almost_empty set
    check_csum(csum, '0);
    if (word_vld || rd_miss)
        report_error("word_vld or rd_miss high after reset");
endtask

task automatic test_stream_words();
    send_bytes(3, 0);
    send_bytes(13, 5);              // five stray bits before these
    check_fifo_state();
    read_words(4);
    check_csum(csum, csum_model);
endtask

task automatic test_levels_flags();
    send_bytes(7, 0);
    check_fifo_state();             // one word and three bytes
    read_words(1);
    check_fifo_state();             // leftover keeps rempty set
    send_bytes(5, 0);
    check_fifo_state();             // two words still count as almost empty
    send_bytes(5, 0);
    check_fifo_state();             // three words so almost_empty drops
    read_words(3);
    check_fifo_state();
endtask

task automatic test_full_drop();
    apply_reset();
    send_bytes(AF_NUM - 1, 0);
    check_fifo_state();             // one byte below almost_full
    send_bytes(1, 0);
    check_fifo_state();             // almost_full right at the threshold
    send_bytes(DEPTH - AF_NUM + 8, 0);  // eight past full
    check_fifo_state();
    read_words(DEPTH / BYTES_PER_WORD);
    check_fifo_state();
    check_csum(csum, csum_model);
endtask

task automatic test_empty_read();
    int   lvl;
    int   n;
    logic miss;
    logic vld;
    lvl  = int'(rd_level);
    miss = 1'b0;
    vld  = 1'b0;
    @(posedge rclk);
    rd_req <= 1'b1;
    @(posedge rclk);
    rd_req <= 1'b0;
    for (n = 0; n < 3; n++)         // a taken read would show word_vld by now
    begin
        @(negedge rclk);
        miss |= rd_miss;
        vld  |= word_vld;
    end
    if (!miss)
        report_error("no rd_miss for a read of an empty fifo");
    if (vld)
        report_error("word_vld came back from an empty fifo");
    check_level("rd_level", LVL_W'(rd_level), LVL_W'(lvl));
endtask

task automatic test_checksum();
    clear_csum();
    send_bytes(40, 0);
    check_fifo_state();
    read_words(10);                 // back to back
    check_csum(csum, csum_model);
    clear_csum();
endtask

`endif

/* dv/tb_ru_rd_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ru_rd_top
    import ru_cfg_pkg::*;
    import ru_data_pkg::*;
();

    localparam int WR_DW    = 9;                    // byte address bits
    localparam int LVL_W    = WR_DW + 1;            // widest level
    localparam int DEPTH    = 1 << WR_DW;           // 512 bytes
    localparam int AF_NUM   = 500;                  // bytes
    localparam int AE_NUM   = 2;                    // words
    localparam int WAIT_MAX = 300;                  // cycles per wait loop

    logic                      rclk;
    logic                      rrst;
    logic                      bit_in;
    logic                      bit_strobe;
    logic                      frame_start;
    logic                      rd_req;
    logic                      csum_clr;
    logic                      word_vld;
    ru_word_t                  word_out;
    logic                      rd_miss;
    ru_csum_t                  csum;
    fifo_flags_t               flags;
    logic [WR_DW:0]            wr_level;
    logic [WR_DW-LANE_SEL_W:0] rd_level;

    int          err_cnt;     // wrong values
    int          other_cnt;   // timeouts and missing pulses
    integer      seed;
    flash_byte_t byte_q[$];   // bytes the fifo should hold, oldest first
    ru_csum_t    csum_model;  // sum of words handed out

    always #10 rclk = ~rclk;  // 20 ns period

    ru_rd_top #(
        .WR_DEPTH_WIDTH   (WR_DW),
        .ALMOST_FULL_NUM  (AF_NUM),
        .ALMOST_EMPTY_NUM (AE_NUM)
    ) u_ru_rd_top (.*);

    // ****************************************
    // compare tasks
    // ****************************************
    task automatic log_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        err_cnt++;
        $display("FAIL t=%0t %s got %0h exp %0h", $time, name, got, exp);
    endtask

    task automatic check_word(input string name, input ru_word_t got, input ru_word_t exp);
        if (got !== exp)
            log_mismatch(name, got, exp);
    endtask

    task automatic check_csum(input ru_csum_t got, input ru_csum_t exp);
        if (got !== exp)
            log_mismatch("csum", got, exp);
    endtask

    task automatic check_flags(input fifo_flags_t got, input fifo_flags_t exp);
        if (got !== exp)
            log_mismatch("flags", 32'(got), 32'(exp));  // wfull af rempty ae
    endtask

    task automatic check_level(input string name, input logic [WR_DW:0] got,
                               input logic [WR_DW:0] exp);
        if (got !== exp)
            log_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic report_error(input string msg);
        other_cnt++;
        $display("ERROR t=%0t %s", $time, msg);
    endtask

    // wait for levels to reach the model then check levels and flags
    task automatic check_fifo_state();
        fifo_flags_t exp;
        int          nb;
        int          n;
        nb = byte_q.size();
        n  = 0;
        @(negedge rclk);
        while ((int'(wr_level) != nb || int'(rd_level) != nb / BYTES_PER_WORD)
               && n < WAIT_MAX)
        begin
            @(negedge rclk);
            n++;
        end
        if (n == WAIT_MAX)
            report_error("timeout waiting for fifo levels to settle");
        exp.wfull        = (nb == DEPTH);
        exp.almost_full  = (nb >= AF_NUM);
        exp.rempty       = (nb < BYTES_PER_WORD);             // partial word reads as empty
        exp.almost_empty = (nb / BYTES_PER_WORD <= AE_NUM);
        check_level("wr_level", wr_level, LVL_W'(nb));
        check_level("rd_level", LVL_W'(rd_level), LVL_W'(nb / BYTES_PER_WORD));
        check_flags(flags, exp);
    endtask

    `include "tb_ru_rd_tests.svh"

    initial
    begin
        rclk        = 1'b0;
        rrst        = 1'b1;
        bit_in      = 1'b0;
        bit_strobe  = 1'b0;
        frame_start = 1'b0;
        rd_req      = 1'b0;
        csum_clr    = 1'b0;
        seed        = 32'hf8be;
        err_cnt     = 0;
        other_cnt   = 0;
        test_reset_state();
        test_stream_words();
        test_levels_flags();
        test_full_drop();
        test_empty_read();
        test_checksum();
        $display("checks done with %0d mismatches and %0d other errors", err_cnt, other_cnt);
        if (err_cnt == 0 && other_cnt == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule : tb_ru_rd_top

`default_nettype wire

/* all.f */
+incdir+dv
source/ru_cfg_pkg.sv
source/ru_data_pkg.sv
source/ru_byte_deser.sv
source/ru_fifo_ctrl.sv
source/ru_fifo_ram.sv
source/ru_word_reader.sv
source/ru_rd_top.sv
dv/tb_ru_rd_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench with verilator, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_ru_rd_top -f all.f -o tb_sim \
    && ./obj_dir/tb_sim | tee sim.log \
    || { echo "build or simulation did not complete"; exit 1; }
grep -qx "Verification passed" sim.log && exit 0 || exit 1
